//--- tests/addr_collect_stim.txt
# T name | C bofs0-2 abeg0-2 aend0-2 beg end exp0-3 | I coord0-2 pitch0-2
# Numbers in hex, exp is the whole bundle expected after that command
T after_reset
C 0010 0020 0030 0000 0000 0000 0008 0008 0008 0 4 321 654 072 12c
I 0001 0002 0003 0001 0010 0100
I 0004 0005 0006 0001 0010 0100
I 0007 0000 0001 0002 0003 0064
I 000a 000a 000a 000a 000a 000a
T partial_window
C 0100 0200 0300 0001 0001 0001 0002 0002 0002 1 3 321 010 003 12c
I 0002 0000 0000 0008 0000 0000
I 0001 0001 0001 0001 0001 0001
T back_pressure
C 0001 0001 0001 0000 0000 0000 0004 0004 0004 0 2 00f 02a 003 12c
C 0002 0002 0002 0004 0004 0004 0008 0008 0008 2 4 00f 02a 051 020
C 0003 0003 0003 0008 0008 0008 000c 000c 000c 0 1 1fe 02a 051 020
I 0005 0000 0000 0003 0000 0000
I 0000 0006 0000 0000 0007 0000
I 0000 0000 0009 0000 0000 0009
I 0001 0002 0003 0004 0005 0006
I 00ff 0000 0000 0002 0000 0000
T metadata
C aaaa bbbb cccc 1111 2222 3333 4444 5555 6666 1 2 1fe 009 051 020
C dead beef cafe 0123 4567 89ab cdef fedc ba98 3 4 1fe 009 051 080
I 0003 0000 0000 0003 0000 0000
I 0000 0000 0002 0000 0000 0040
T early_items
C 0000 0000 0000 0000 0000 0000 ffff ffff ffff 0 3 003 fff 800 080
I ffff ffff ffff ffff ffff ffff
I 1000 0001 0000 0007 0fff 0000
I 0800 0800 0000 0002 0001 0000
T single_slot
C 0006 0006 0006 0001 0002 0003 0004 0005 0006 2 3 003 fff 009 080
C 0007 0007 0007 0000 0000 0000 0001 0001 0001 0 1 121 fff 009 080
C 0008 0008 0008 0002 0002 0002 0003 0003 0003 3 4 121 fff 009 000
I 0002 0003 0004 0001 0001 0001
I 0011 0000 0000 0011 0000 0000
I 0000 0000 0000 0005 0005 0005

//--- sim.f
common/tau_cfg_pkg.sv
common/tau_types_pkg.sv
source/rdyack_forward.sv
source/linear_addr_calc.sv
collector/linear_collector.sv
source/addr_collect_top.sv
tests/addr_collect_checker.sv
tests/addr_collect_tb.sv

//--- Makefile
# Verilator build and run for the address collection testbench

TOP := addr_collect_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -f sim.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	out="$$(./obj_dir/sim +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F "*** TEST PASSED ***"

clean:
	rm -rf obj_dir

//--- tests/addr_collect_tb.sv
// Address collection testbench
// Replays the stim file through the top level under random back-pressure
// and checks every bundle against the file and a reference sum

`timescale 1ns/1ps

module addr_collect_tb;

	import tau_cfg_pkg::*;
	import tau_types_pkg::*;

	localparam int    LBW        = LOCAL_ADDR_BW0;
	localparam string STIM_FILE  = "tests/addr_collect_stim.txt";
	// Test 3 runs with heavy back-pressure, test 5 sends its items first
	localparam int    SLOW_TEST  = 2;
	localparam int    EARLY_TEST = 4;

	// ================================================
	// DUT signals
	// ================================================

	logic         i_clk;
	logic         i_rst;
	logic         i_range_rdy;
	logic         o_range_ack;
	range_cmd_t   i_range;
	logic         i_item_rdy;
	logic         o_item_ack;
	coord_item_t  i_item;
	logic         o_bundle_rdy;
	logic         i_bundle_ack;
	addr_bundle_t o_bundle;

	// Stim records, one entry per command or item
	string        test_name[$];
	int           cmd_test[$];
	range_cmd_t   cmd_q[$];
	linears_t     exp_q[$];
	int           item_test[$];
	coord_item_t  item_q[$];
	// Bundles in arrival order
	addr_bundle_t got_q[$];

	// Reference slot contents, kept across commands like the collector
	linears_t     model;
	int           item_pos;
	string        cur_test;
	int           n_records;
	int           ack_pct;
	int           n_checks;
	int           n_errors;

	addr_collect_top #(
		.LBW (LBW)
	) dut (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_range_rdy  (i_range_rdy),
		.o_range_ack  (o_range_ack),
		.i_range      (i_range),
		.i_item_rdy   (i_item_rdy),
		.o_item_ack   (o_item_ack),
		.i_item       (i_item),
		.o_bundle_rdy (o_bundle_rdy),
		.i_bundle_ack (i_bundle_ack),
		.o_bundle     (o_bundle)
	);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	// ================================================
	// Helpers
	// ================================================

	task automatic check_val(input string what, input logic [63:0] exp,
			input logic [63:0] act);
		n_checks++;
		if (exp !== act) begin
			$display("FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
			n_errors++;
		end
	endtask

	// Sum of coordinate times pitch, wrapped to LBW bits
	function automatic logic [LOCAL_ADDR_BW0-1:0] ref_sum(input coord_item_t it);
		longint acc;
		acc = 0;
		for (int d = 0; d < VDIM; d++) begin
			acc += longint'(it.coord[d]) * longint'(it.pitch[d]);
		end
		return LOCAL_ADDR_BW0'(acc % (longint'(1) << LBW));
	endfunction

	task automatic load_stim();
		int          fd;
		int          n;
		int          v[15];
		string       line;
		string       name;
		range_cmd_t  c;
		coord_item_t it;
		linears_t    e;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open stim file %s", STIM_FILE);
			n_errors++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			// Skip comments and blank lines
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			n_records++;
			if (line[0] == "T") begin
				n = $sscanf(line, "T %s", name);
				test_name.push_back(name);
			end else if (line[0] == "C") begin
				n = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
					v[10], v[11], v[12], v[13], v[14]);
				if (n != 15) begin
					$display("malformed command record: %s", line);
					n_errors++;
				end
				for (int d = 0; d < VDIM; d++) begin
					c.bofs[d] = WORK_BW'(v[d]);
					c.abeg[d] = WORK_BW'(v[3 + d]);
					c.aend[d] = WORK_BW'(v[6 + d]);
				end
				c.beg  = ICFG_BW'(v[9]);
				c.end_ = ICFG_BW'(v[10]);
				for (int s = 0; s < N_ICFG; s++) begin
					e[s] = LOCAL_ADDR_BW0'(v[11 + s]);
				end
				cmd_q.push_back(c);
				exp_q.push_back(e);
				cmd_test.push_back(test_name.size() - 1);
			end else begin
				n = $sscanf(line, "I %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5]);
				if (n != 6) begin
					$display("malformed item record: %s", line);
					n_errors++;
				end
				for (int d = 0; d < VDIM; d++) begin
					it.coord[d] = WORK_BW'(v[d]);
					it.pitch[d] = WORK_BW'(v[3 + d]);
				end
				item_q.push_back(it);
				item_test.push_back(test_name.size() - 1);
			end
		end
		$fclose(fd);
	endtask

	// ================================================
	// Drivers
	// ================================================

	// Rdy stays high between commands of one test, so they go back to back
	task automatic send_cmds(input int t);
		for (int k = 0; k < cmd_q.size(); k++) begin
			if (cmd_test[k] == t) begin
				@(posedge i_clk);
				i_range_rdy <= 1'b1;
				i_range     <= cmd_q[k];
				@(negedge i_clk);
				while (!o_range_ack) @(negedge i_clk);
			end
		end
		@(posedge i_clk);
		i_range_rdy <= 1'b0;
	endtask

	task automatic send_items(input int t);
		for (int k = 0; k < item_q.size(); k++) begin
			if (item_test[k] == t) begin
				@(posedge i_clk);
				i_item_rdy <= 1'b1;
				i_item     <= item_q[k];
				@(negedge i_clk);
				while (!o_item_ack) @(negedge i_clk);
			end
		end
		@(posedge i_clk);
		i_item_rdy <= 1'b0;
	endtask

	// Random ack, dropped after every transfer so it never outlives rdy
	always @(posedge i_clk) begin
		if (!i_rst || i_bundle_ack) begin
			i_bundle_ack <= 1'b0;
		end else if (o_bundle_rdy && ($urandom % 100 < ack_pct)) begin
			i_bundle_ack <= 1'b1;
		end
	end

	// Bundle taken on the coming edge
	always @(negedge i_clk) begin
		if (i_bundle_ack && o_bundle_rdy) begin
			got_q.push_back(o_bundle);
		end
	end

	// ================================================
	// Test sequence
	// ================================================

	task automatic run_test(input int t);
		int           first;
		int           count;
		int           j;
		int           errs_before;
		addr_bundle_t got;
		cur_test    = test_name[t];
		errs_before = n_errors;
		first       = got_q.size();
		count       = 0;
		for (int k = 0; k < cmd_q.size(); k++) begin
			if (cmd_test[k] == t) begin
				count++;
			end
		end
		ack_pct = (t == SLOW_TEST) ? 20 : 50;
		fork
			begin
				if (t == EARLY_TEST) begin
					repeat (12) @(posedge i_clk);
				end
				send_cmds(t);
			end
			send_items(t);
		join
		while (got_q.size() < first + count) @(posedge i_clk);
		// Quiet window to catch a surplus bundle
		repeat (20) @(posedge i_clk);
		check_val("bundle count", 64'(count), 64'(got_q.size() - first));
		j = 0;
		for (int k = 0; k < cmd_q.size() && j < got_q.size() - first; k++) begin
			if (cmd_test[k] == t) begin
				// Window slots take the next items in order
				for (int s = int'(cmd_q[k].beg); s < int'(cmd_q[k].end_); s++) begin
					model[s] = ref_sum(item_q[item_pos]);
					item_pos++;
				end
				got = got_q[first + j];
				j++;
				check_val("bofs", 64'(cmd_q[k].bofs), 64'(got.bofs));
				check_val("abeg", 64'(cmd_q[k].abeg), 64'(got.abeg));
				check_val("aend", 64'(cmd_q[k].aend), 64'(got.aend));
				for (int s = 0; s < N_ICFG; s++) begin
					check_val($sformatf("slot %0d vs stim", s), 64'(exp_q[k][s]),
						64'(got.linears[s]));
					check_val($sformatf("slot %0d vs sum", s), 64'(model[s]),
						64'(got.linears[s]));
				end
			end
		end
		$display("test %0d %s: %0d bundles, %0d errors", t + 1, cur_test, count,
			n_errors - errs_before);
	endtask

	initial begin
		void'($urandom(32'h4ceb_a2ed));
		i_rst        = 1'b0;
		i_range_rdy  = 1'b0;
		i_range      = '0;
		i_item_rdy   = 1'b0;
		i_item       = '0;
		i_bundle_ack = 1'b0;
		model        = '0;
		item_pos     = 0;
		ack_pct      = 50;
		n_checks     = 0;
		n_errors     = 0;
		load_stim();
		repeat (5) @(posedge i_clk);
		i_rst <= 1'b1;
		@(negedge i_clk);
		cur_test = "reset";
		check_val("o_bundle_rdy", 64'(0), 64'(o_bundle_rdy));
		if (n_errors == 0) begin
			for (int t = 0; t < test_name.size(); t++) begin
				run_test(t);
			end
		end
		if (dut.u_checker.n_fail != 0) begin
			$display("protocol assertions failed %0d times", dut.u_checker.n_fail);
			n_errors += dut.u_checker.n_fail;
		end
		$display("summary: %0d tests, %0d checks, %0d errors", test_name.size(),
			n_checks, n_errors);
		if (n_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Watchdog, 200 cycles per stim record
	initial begin
		wait (n_records > 0);
		repeat (200 * n_records) @(posedge i_clk);
		$display("timeout: run still busy after %0d cycles", 200 * n_records);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- tests/addr_collect_checker.sv
// Protocol checker for the address collection path
// Bound into the top level, watches every rdy/ack link and the reset state

`timescale 1ns/1ps

module addr_collect_checker #(
	parameter int LBW = tau_cfg_pkg::LOCAL_ADDR_BW0
) (
	input logic                        i_clk,
	input logic                        i_rst,
	input logic                        i_range_rdy,
	input logic                        i_range_ack,
	input tau_types_pkg::range_cmd_t   i_range,
	input logic                        i_lin_rdy,
	input logic                        i_lin_ack,
	input logic [LBW-1:0]              i_linear,
	input logic                        i_coll_rdy,
	input logic                        i_coll_ack,
	input tau_types_pkg::addr_bundle_t i_coll_bundle,
	input logic                        i_out_rdy,
	input logic                        i_out_ack,
	input tau_types_pkg::addr_bundle_t i_out_bundle
);

	// Number of assertion failures so far
	int n_fail = 0;

	// ================================================
	// Payload hold until ack
	// ================================================

	a_range_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_range_rdy && !i_range_ack |=> i_range_rdy && $stable(i_range))
		else begin $error("range command changed before ack"); n_fail++; end

	a_lin_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_lin_rdy && !i_lin_ack |=> i_lin_rdy && $stable(i_linear))
		else begin $error("linear address changed before ack"); n_fail++; end

	a_coll_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_coll_rdy && !i_coll_ack |=> i_coll_rdy && $stable(i_coll_bundle))
		else begin $error("collector bundle changed before ack"); n_fail++; end

	a_out_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_out_rdy && !i_out_ack |=> i_out_rdy && $stable(i_out_bundle))
		else begin $error("output bundle changed before ack"); n_fail++; end

	// ================================================
	// Ack only with rdy, idle out of reset
	// ================================================

	// Internal acks are gated by their rdy inside each block
	a_ack_rdy: assert property (@(posedge i_clk) disable iff (!i_rst)
		!i_out_ack || i_out_rdy)
		else begin $error("ack seen without rdy"); n_fail++; end

	a_reset_idle: assert property (@(posedge i_clk) $rose(i_rst) |-> !i_out_rdy)
		else begin $error("bundle rdy high right after reset"); n_fail++; end

endmodule

bind addr_collect_top addr_collect_checker #(
	.LBW (LBW)
) u_checker (
	.i_clk         (i_clk),
	.i_rst         (i_rst),
	.i_range_rdy   (range_rdy),
	.i_range_ack   (range_ack),
	.i_range       (range_cmd),
	.i_lin_rdy     (lin_rdy),
	.i_lin_ack     (lin_ack),
	.i_linear      (linear),
	.i_coll_rdy    (bundle_rdy),
	.i_coll_ack    (bundle_ack),
	.i_coll_bundle (bundle),
	.i_out_rdy     (o_bundle_rdy),
	.i_out_ack     (i_bundle_ack),
	.i_out_bundle  (o_bundle)
);

//--- source/addr_collect_top.sv
// Address collection path top level
// Range slice, linear calculator, collector and bundle slice in a chain

`timescale 1ns/1ps

module addr_collect_top #(
	parameter int LBW = tau_cfg_pkg::LOCAL_ADDR_BW0
) (
	input  logic                        i_clk,
	input  logic                        i_rst,
	// Range commands from the outside
	input  logic                        i_range_rdy,
	output logic                        o_range_ack,
	input  tau_types_pkg::range_cmd_t   i_range,
	// Coordinate items from the outside
	input  logic                        i_item_rdy,
	output logic                        o_item_ack,
	input  tau_types_pkg::coord_item_t  i_item,
	// Collected bundles to the outside
	output logic                        o_bundle_rdy,
	input  logic                        i_bundle_ack,
	output tau_types_pkg::addr_bundle_t o_bundle
);

	import tau_types_pkg::*;

	// ================================================
	// Internal links
	// ================================================

	// Range slice to collector
	logic            range_rdy;
	logic            range_ack;
	range_cmd_t      range_cmd;

	// Calculator to collector
	logic            lin_rdy;
	logic            lin_ack;
	logic [LBW-1:0]  linear;

	// Collector to bundle slice
	logic            bundle_rdy;
	logic            bundle_ack;
	addr_bundle_t    bundle;

	// ================================================
	// Instances
	// ================================================

	// Command register slice
	rdyack_forward #(
		.PAYLOAD_T (range_cmd_t)
	) u_range_fwd (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_src_rdy (i_range_rdy),
		.o_src_ack (o_range_ack),
		.i_src     (i_range),
		.o_dst_rdy (range_rdy),
		.i_dst_ack (range_ack),
		.o_dst     (range_cmd)
	);

	linear_addr_calc #(
		.LBW (LBW)
	) u_calc (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_item_rdy (i_item_rdy),
		.o_item_ack (o_item_ack),
		.i_item     (i_item),
		.o_lin_rdy  (lin_rdy),
		.i_lin_ack  (lin_ack),
		.o_linear   (linear)
	);

	linear_collector #(
		.LBW (LBW)
	) u_collect (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_range_rdy  (range_rdy),
		.o_range_ack  (range_ack),
		.i_range      (range_cmd),
		.i_lin_rdy    (lin_rdy),
		.o_lin_ack    (lin_ack),
		.i_linear     (linear),
		.o_bundle_rdy (bundle_rdy),
		.i_bundle_ack (bundle_ack),
		.o_bundle     (bundle)
	);

	// Output slice, frees the collector as soon as it registers the bundle
	rdyack_forward #(
		.PAYLOAD_T (addr_bundle_t)
	) u_bundle_fwd (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_src_rdy (bundle_rdy),
		.o_src_ack (bundle_ack),
		.i_src     (bundle),
		.o_dst_rdy (o_bundle_rdy),
		.i_dst_ack (i_bundle_ack),
		.o_dst     (o_bundle)
	);

endmodule

//--- collector/linear_collector.sv
// Linear address collector
// Latches one range command, fills slots beg..end-1 with incoming
// addresses and offers all slots with the command metadata as a bundle

`timescale 1ns/1ps

module linear_collector #(
	parameter int LBW = tau_cfg_pkg::LOCAL_ADDR_BW0
) (
	input  logic                        i_clk,
	input  logic                        i_rst,
	// Range command input
	input  logic                        i_range_rdy,
	output logic                        o_range_ack,
	input  tau_types_pkg::range_cmd_t   i_range,
	// Linear address input
	input  logic                        i_lin_rdy,
	output logic                        o_lin_ack,
	input  logic [LBW-1:0]              i_linear,
	// Bundle output
	output logic                        o_bundle_rdy,
	input  logic                        i_bundle_ack,
	output tau_types_pkg::addr_bundle_t o_bundle
);

	import tau_cfg_pkg::*;
	import tau_types_pkg::*;

	// ================================================
	// State
	// ================================================

	// Control flags, idle when both are low
	logic               collecting_r;
	logic               bundle_rdy_r;
	logic               idle;

	// Window bookkeeping
	logic [ICFG_BW-1:0] end_r;
	logic [ICFG_BW-1:0] cur_idx_r;
	logic [ICFG_BW-1:0] next_idx;
	logic               is_last;

	// Latched command vectors
	work_vec_t          bofs_r;
	work_vec_t          abeg_r;
	work_vec_t          aend_r;

	// Slot contents, kept across commands outside the window
	linears_t           slots_r;

	// ================================================
	// Handshake
	// ================================================

	assign idle = !collecting_r && !bundle_rdy_r;

	// New command only between bundles
	assign o_range_ack = i_range_rdy && idle;

	// Addresses wait until a command has opened a window
	assign o_lin_ack = i_lin_rdy && collecting_r;

	// Last address of the window goes to slot end-1
	assign next_idx = cur_idx_r + ICFG_BW'(1);
	assign is_last  = next_idx == end_r;

	assign o_bundle_rdy = bundle_rdy_r;

	// Bundle is a view of the latched metadata and the slots
	always_comb begin
		o_bundle.bofs    = bofs_r;
		o_bundle.abeg    = abeg_r;
		o_bundle.aend    = aend_r;
		o_bundle.linears = slots_r;
	end

	// ================================================
	// Control FSM
	// ================================================

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			collecting_r <= 1'b0;
			bundle_rdy_r <= 1'b0;
			end_r        <= '0;
			cur_idx_r    <= '0;
		end else begin
			// Open the window at beg
			if (o_range_ack) begin
				collecting_r <= 1'b1;
				cur_idx_r    <= i_range.beg;
				end_r        <= i_range.end_;
			end
			// Step through the window, close it on the last slot
			if (o_lin_ack) begin
				cur_idx_r <= next_idx;
				if (is_last) begin
					collecting_r <= 1'b0;
					bundle_rdy_r <= 1'b1;
				end
			end
			// Bundle taken, back to idle
			if (bundle_rdy_r && i_bundle_ack) begin
				bundle_rdy_r <= 1'b0;
			end
		end
	end

	// ================================================
	// Metadata and slots
	// ================================================

	// Command vectors are captured with the command
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			bofs_r <= '0;
			abeg_r <= '0;
			aend_r <= '0;
		end else if (o_range_ack) begin
			bofs_r <= i_range.bofs;
			abeg_r <= i_range.abeg;
			aend_r <= i_range.aend;
		end
	end

	// One slot loads per accepted address, resized to the bundle width
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			slots_r <= '0;
		end else begin
			for (int s = 0; s < N_ICFG; s++) begin
				if (o_lin_ack && (cur_idx_r == ICFG_BW'(s))) begin
					slots_r[s] <= LOCAL_ADDR_BW0'(i_linear);
				end
			end
		end
	end

endmodule

//--- source/linear_addr_calc.sv
// Linear address calculator
// Two-stage pipeline: per-dimension products of coordinate and pitch,
// then their sum truncated to the local address width

`timescale 1ns/1ps

module linear_addr_calc #(
	parameter int LBW = tau_cfg_pkg::LOCAL_ADDR_BW0
) (
	input  logic                       i_clk,
	input  logic                       i_rst,
	// Coordinate item input
	input  logic                       i_item_rdy,
	output logic                       o_item_ack,
	input  tau_types_pkg::coord_item_t i_item,
	// Linear address output
	output logic                       o_lin_rdy,
	input  logic                       i_lin_ack,
	output logic [LBW-1:0]             o_linear
);

	import tau_cfg_pkg::*;

	// Full product width of one coordinate times one pitch
	localparam int PBW = 2 * WORK_BW;

	// ================================================
	// Pipeline registers
	// ================================================

	// Stage one holds the products
	logic                      s1_valid_r;
	logic [VDIM-1:0][PBW-1:0]  s1_prod_r;

	// Stage two holds the summed address
	logic                      s2_valid_r;
	logic [LBW-1:0]            s2_sum_r;

	// Advance enables, stage two drains first
	logic                      s2_adv;
	logic                      s1_adv;

	// Modulo 2^LBW sum of the stage one products
	logic [LBW-1:0]            sum_w;

	// ================================================
	// Stall control
	// ================================================

	// Stage two moves when empty or when the consumer takes its address
	assign s2_adv = !s2_valid_r || i_lin_ack;

	// Stage one moves when empty or when stage two can take its entry
	assign s1_adv = !s1_valid_r || s2_adv;

	// Input ack drops only with both stages full and the output stalled
	assign o_item_ack = i_item_rdy && s1_adv;

	assign o_lin_rdy = s2_valid_r;
	assign o_linear  = s2_sum_r;

	// ================================================
	// Adder tree
	// ================================================

	// Truncating each product first gives the same low LBW bits
	always_comb begin
		sum_w = '0;
		for (int d = 0; d < VDIM; d++) begin
			sum_w = sum_w + LBW'(s1_prod_r[d]);
		end
	end

	// ================================================
	// Valid flags
	// ================================================

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			s1_valid_r <= 1'b0;
			s2_valid_r <= 1'b0;
		end else begin
			if (s1_adv) begin
				s1_valid_r <= i_item_rdy;
			end
			if (s2_adv) begin
				s2_valid_r <= s1_valid_r;
			end
		end
	end

	// ================================================
	// Datapath
	// ================================================

	// Products at full width, one multiplier per dimension
	always_ff @(posedge i_clk) begin
		if (o_item_ack) begin
			for (int d = 0; d < VDIM; d++) begin
				s1_prod_r[d] <= PBW'(i_item.coord[d]) * PBW'(i_item.pitch[d]);
			end
		end
	end

	// Sum register follows its valid flag
	always_ff @(posedge i_clk) begin
		if (s2_adv && s1_valid_r) begin
			s2_sum_r <= sum_w;
		end
	end

endmodule

//--- source/rdyack_forward.sv
// Single-entry register slice on a rdy/ack link
// Holds one payload of any type and registers it toward the consumer

`timescale 1ns/1ps

module rdyack_forward #(
	parameter type PAYLOAD_T = logic
) (
	input  logic     i_clk,
	input  logic     i_rst,
	// Producer side
	input  logic     i_src_rdy,
	output logic     o_src_ack,
	input  PAYLOAD_T i_src,
	// Consumer side
	output logic     o_dst_rdy,
	input  logic     i_dst_ack,
	output PAYLOAD_T o_dst
);

	// ================================================
	// State
	// ================================================

	logic     full_r;
	PAYLOAD_T data_r;

	// ================================================
	// Handshake
	// ================================================

	// Take a new payload when empty, or when the held one leaves this cycle
	assign o_src_ack = i_src_rdy && (!full_r || i_dst_ack);

	assign o_dst_rdy = full_r;
	assign o_dst     = data_r;

	// Full flag follows accepts and drains
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			full_r <= 1'b0;
		end else if (o_src_ack) begin
			full_r <= 1'b1;
		end else if (i_dst_ack) begin
			full_r <= 1'b0;
		end
	end

	// Payload register, loaded only on an accepted transfer
	always_ff @(posedge i_clk) begin
		if (o_src_ack) begin
			data_r <= i_src;
		end
	end

endmodule

//--- common/tau_types_pkg.sv
// Address unit payload types
// Packed structs for range commands, coordinate items and the
// bundles that the collector hands downstream

package tau_types_pkg;

	import tau_cfg_pkg::*;

	// ================================================
	// Vectors
	// ================================================

	// One WORK_BW element per dimension, dimension 0 in the low bits
	typedef logic [VDIM-1:0][WORK_BW-1:0] work_vec_t;

	// All slot addresses of one bundle, slot 0 in the low bits
	typedef logic [N_ICFG-1:0][LOCAL_ADDR_BW0-1:0] linears_t;

	// ================================================
	// Range command
	// ================================================

	// Block offset and per-dimension bounds, plus the slot window
	typedef struct packed {
		work_vec_t          bofs;
		work_vec_t          abeg;
		work_vec_t          aend;
		// First slot written by this command
		logic [ICFG_BW-1:0] beg;
		// One past the last slot written
		logic [ICFG_BW-1:0] end_;
	} range_cmd_t;

	// ================================================
	// Coordinate item
	// ================================================

	// Linear address is the sum over dimensions of coord times pitch
	typedef struct packed {
		work_vec_t coord;
		work_vec_t pitch;
	} coord_item_t;

	// ================================================
	// Collected bundle
	// ================================================

	// Command metadata travels with the slot contents
	typedef struct packed {
		work_vec_t bofs;
		work_vec_t abeg;
		work_vec_t aend;
		linears_t  linears;
	} addr_bundle_t;

endpackage

//--- common/tau_cfg_pkg.sv
// Address unit configuration
// Dimension counts, coordinate widths and the derived slot index width
// shared by the calculator, the collector and the testbench

package tau_cfg_pkg;

	// ================================================
	// Base dimensions
	// ================================================

	// Number of tensor dimensions handled per item
	localparam int VDIM = 3;

	// Width of one offset, begin, end, coordinate or pitch element
	localparam int WORK_BW = 16;

	// Default width of a linear local address
	localparam int LOCAL_ADDR_BW0 = 12;

	// Number of address slots in one collected bundle
	localparam int N_ICFG = 4;

	// ================================================
	// Derived widths
	// ================================================

	// Slot index must also hold N_ICFG itself, since the window end is exclusive
	localparam int ICFG_BW = $clog2(N_ICFG + 1);

endpackage
